// File: design/tx_buf_defs.svh
////////////////////////////////////////////////////////////
// sizes of the tx packet buffer
// include in packages and modules that need the raw widths
////////////////////////////////////////////////////////////

`ifndef TX_BUF_DEFS_SVH
`define TX_BUF_DEFS_SVH

// ring address width, 2**9 = 512 words
`define TX_BUF_AW 9

// stream data width
`define TX_BUF_DW 64

// one keep bit per data byte
`define TX_BUF_KW (`TX_BUF_DW/8)

`endif

// File: design/tx_buf_stream_pkg.sv
////////////////////////////////////////////////////////////
// stream word types for the tx packet buffer
// shared by the writer, the ram and the reader
////////////////////////////////////////////////////////////

`default_nettype none

`include "tx_buf_defs.svh"

package tx_buf_stream_pkg;

    typedef logic [`TX_BUF_DW-1:0] tx_data_t;   // one data word
    typedef logic [`TX_BUF_KW-1:0] tx_keep_t;   // bit i enables byte i

    // word as it sits in the ring
    typedef struct packed {
        tx_data_t data;
        tx_keep_t keep;
        logic     last;     // end of packet
    } tx_entry_t;

endpackage

`default_nettype wire

// File: design/tx_buf_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// pointer and count types for tx buffer bookkeeping
// used by the writer, reader and control
////////////////////////////////////////////////////////////

`default_nettype none

`include "tx_buf_defs.svh"

package tx_buf_ctrl_pkg;

    // slot index in the ring, wraps naturally
    typedef logic [`TX_BUF_AW-1:0] buf_addr_t;

    // 0 .. 2**AW words, one extra bit for a full ring
    typedef logic [`TX_BUF_AW:0] buf_count_t;

endpackage

`default_nettype wire

// File: design/tx_buf_ram.sv
////////////////////////////////////////////////////////////
// dual-port word ram of the tx ring
// write lands 2 cycles after presentation, read data 1 cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tx_buf_ram #(
    parameter int AW = 9,
    parameter int W  = 64
) (
    input  logic          clk,
    input  logic [AW-1:0] wr_addr,
    input  logic [W-1:0]  wr_entry,
    input  logic [AW-1:0] rd_addr,
    output logic [W-1:0]  rd_entry
);

    logic [AW-1:0] wr_addr_q;       // write port stage
    logic [W-1:0]  wr_entry_q;
    logic [W-1:0]  mem [2**AW];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////
    // no enable, the registered slot is rewritten every cycle
    always_ff @(posedge clk) begin
        wr_addr_q         <= wr_addr;
        wr_entry_q        <= wr_entry;
        mem[wr_addr_q]    <= wr_entry_q;
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_addr];   // address taken straight from the reader
    end

    // a slot shared by both ports may only see the idle rewrite of
    // its own contents, never fresh data
    a_no_collision: assert property (@(posedge clk)
        (!$isunknown({wr_addr_q, rd_addr}) && wr_addr_q == rd_addr)
            |-> wr_entry_q == mem[wr_addr_q]);

endmodule

`default_nettype wire

// File: design/tx_buf_writer.sv
////////////////////////////////////////////////////////////
// write side of the tx buffer
// accepts host words into the ring and reports landed writes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tx_buf_writer
    import tx_buf_stream_pkg::*, tx_buf_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  tx_data_t  in_data,
    input  tx_keep_t  in_keep,
    input  logic      in_last,
    input  logic      in_valid,
    output logic      in_ready,
    input  logic      wr_allow,
    output logic      wr_accept,
    output logic      wr_landed,
    output logic      wr_landed_last,
    output buf_addr_t wr_addr,
    output tx_entry_t wr_entry
);

    buf_addr_t wr_ptr;      // next free slot
    logic      land_s1;     // accept delayed by one
    logic      last_s1;

    assign in_ready  = wr_allow;
    assign wr_accept = in_valid & in_ready;

    ////////////////////////////////////////////////////////////
    // pointer and landing pipeline
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr         <= '0;
            wr_addr        <= '0;
            land_s1        <= 1'b0;
            last_s1        <= 1'b0;
            wr_landed      <= 1'b0;
            wr_landed_last <= 1'b0;
        end else begin
            land_s1        <= wr_accept;
            last_s1        <= wr_accept & in_last;
            wr_landed      <= land_s1;      // matches ram write stage
            wr_landed_last <= last_s1;
            if (wr_accept) begin
                wr_addr <= wr_ptr;          // held here while idle
                wr_ptr  <= wr_ptr + 1'b1;   // wraps mod ring size
            end
        end
    end

    // word register, idle cycles keep the last one in place
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_entry.data <= in_data;
            wr_entry.keep <= in_keep;
            wr_entry.last <= in_last;
        end
    end

    // only the last word of a packet may be partial
    a_full_keep: assert property (@(posedge clk) disable iff (reset)
        (wr_accept && !in_last) |-> (&in_keep));

endmodule

`default_nettype wire

// File: design/tx_buf_ctrl.sv
////////////////////////////////////////////////////////////
// bookkeeping of the tx ring
// tracks free space and committed packets, gates both sides
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tx_buf_defs.svh"

module tx_buf_ctrl
    import tx_buf_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic wr_accept,
    input  logic wr_landed,
    input  logic wr_landed_last,
    input  logic rd_issue,
    output logic wr_allow,
    output logic rd_allow
);

    localparam buf_count_t BUF_DEPTH = buf_count_t'(1) << `TX_BUF_AW;

    buf_count_t occupancy;      // accepted and not yet read
    buf_count_t pending;        // landed words of the open packet
    buf_count_t committed;      // words of whole packets, unread
    buf_count_t commit_add;     // words moving over this cycle

    ////////////////////////////////////////////////////////////
    // gating
    ////////////////////////////////////////////////////////////
    assign wr_allow = occupancy < BUF_DEPTH;
    assign rd_allow = committed != '0;

    // closing word plus everything landed before it
    assign commit_add = wr_landed_last ? pending + 1'b1 : '0;

    ////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            // space freed at read issue, data already past the write stage
            occupancy <= occupancy + buf_count_t'(wr_accept)
                                   - buf_count_t'(rd_issue);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (wr_landed_last) begin
            pending <= '0;                  // packet closed
        end else if (wr_landed) begin
            pending <= pending + 1'b1;
        end
    end

    // packet readable from the cycle after its last word lands
    always_ff @(posedge clk) begin
        if (reset) begin
            committed <= '0;
        end else begin
            committed <= committed + commit_add - buf_count_t'(rd_issue);
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_occ_bound: assert property (@(posedge clk) disable iff (reset)
        occupancy <= BUF_DEPTH);

    // the reader must never run ahead of whole packets
    a_rd_committed: assert property (@(posedge clk) disable iff (reset)
        rd_issue |-> committed != '0);

endmodule

`default_nettype wire

// File: design/tx_buf_reader.sv
////////////////////////////////////////////////////////////
// read side of the tx buffer
// pulls committed words from the ring into a 2-entry skid
// fifo whose head drives the mac-side stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tx_buf_reader
    import tx_buf_stream_pkg::*, tx_buf_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_allow,
    output logic      rd_issue,
    output buf_addr_t rd_addr,
    input  tx_entry_t rd_entry,
    output tx_data_t  out_data,
    output tx_keep_t  out_keep,
    output logic      out_last,
    output logic      out_valid,
    input  logic      out_ready
);

    buf_addr_t rd_ptr;          // next unread slot
    logic      in_flight;       // ram data returns this cycle
    tx_entry_t fifo_mem [2];
    logic      wr_idx;
    logic      rd_idx;
    logic [1:0] fifo_count;
    logic      push;
    logic      pop;
    logic [2:0] fill;           // fifo words after this cycle, reads included
    tx_entry_t head;

    ////////////////////////////////////////////////////////////
    // read issue
    ////////////////////////////////////////////////////////////
    assign push = in_flight;
    assign pop  = out_valid & out_ready;
    assign fill = {1'b0, fifo_count} + {2'b00, in_flight} - {2'b00, pop};

    assign rd_issue = rd_allow && (fill < 3'd2);

    // with nothing committed, park on the last slot read so a fresh
    // write at rd_ptr never shares the slot
    assign rd_addr = rd_allow ? rd_ptr : rd_ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr    <= '0;
            in_flight <= 1'b0;
        end else begin
            in_flight <= rd_issue;          // 1-cycle ram latency
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // skid fifo
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx     <= 1'b0;
            rd_idx     <= 1'b0;
            fifo_count <= '0;
        end else begin
            if (push) wr_idx <= ~wr_idx;
            if (pop)  rd_idx <= ~rd_idx;
            fifo_count <= fifo_count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_idx] <= rd_entry;   // returning ram word
        end
    end

    assign head      = fifo_mem[rd_idx];
    assign out_valid = fifo_count != '0;
    assign out_data  = head.data;
    assign out_keep  = head.keep;
    assign out_last  = head.last;

    // stalled word holds until taken
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_data) && $stable(out_keep)
                       && $stable(out_last)));

endmodule

`default_nettype wire

// File: design/tx_buf_top.sv
////////////////////////////////////////////////////////////
// tx packet buffer, store-and-forward between host and mac
// writer and reader around a dual-port ring and its control
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tx_buf_defs.svh"

module tx_buf_top
    import tx_buf_stream_pkg::*, tx_buf_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    // host side
    input  tx_data_t in_data,
    input  tx_keep_t in_keep,
    input  logic     in_last,
    input  logic     in_valid,
    output logic     in_ready,
    // mac side
    output tx_data_t out_data,
    output tx_keep_t out_keep,
    output logic     out_last,
    output logic     out_valid,
    input  logic     out_ready
);

    logic      wr_accept;
    logic      wr_landed;
    logic      wr_landed_last;
    logic      wr_allow;
    logic      rd_allow;
    logic      rd_issue;
    buf_addr_t wr_addr;
    buf_addr_t rd_addr;
    tx_entry_t wr_entry;
    tx_entry_t rd_entry;

    tx_buf_writer tx_buf_writer_i (
        .clk, .reset,
        .in_data, .in_keep, .in_last, .in_valid, .in_ready,
        .wr_allow, .wr_accept, .wr_landed, .wr_landed_last,
        .wr_addr, .wr_entry
    );

    // ring sized from the shared defines
    tx_buf_ram #(
        .AW (`TX_BUF_AW),
        .W  ($bits(tx_entry_t))
    ) tx_buf_ram_i (
        .clk, .wr_addr, .wr_entry, .rd_addr, .rd_entry
    );

    tx_buf_ctrl tx_buf_ctrl_i (
        .clk, .reset,
        .wr_accept, .wr_landed, .wr_landed_last, .rd_issue,
        .wr_allow, .rd_allow
    );

    tx_buf_reader tx_buf_reader_i (
        .clk, .reset,
        .rd_allow, .rd_issue, .rd_addr, .rd_entry,
        .out_data, .out_keep, .out_last, .out_valid, .out_ready
    );

endmodule

`default_nettype wire

// File: verif/tx_buf_tb.sv
////////////////////////////////////////////////////////////
// testbench of the tx packet buffer
// random packets in, queue model checks every output word,
// plus back-pressure, store-and-forward and ring wraparound
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tx_buf_defs.svh"

module tx_buf_tb
    import tx_buf_stream_pkg::*;
;

    localparam int RING_WORDS = 1 << `TX_BUF_AW;
    localparam int SKID_WORDS = 2;      // reader fifo, space freed at issue

    logic      clk;
    logic      reset;
    tx_data_t  in_data;
    tx_keep_t  in_keep;
    logic      in_last;
    logic      in_valid;
    logic      in_ready;
    tx_data_t  out_data;
    tx_keep_t  out_keep;
    logic      out_last;
    logic      out_valid;
    logic      out_ready;

    logic [31:0] in_lfsr;               // stimulus stream
    logic [31:0] rdy_lfsr;              // out_ready stream
    logic [63:0] ready_bits;
    logic [1:0]  ready_mode;            // 0 always, 1 random, 2 held low
    tx_entry_t   exp_q [$];             // reference model
    tx_entry_t   got_entry;
    tx_entry_t   exp_entry;
    tx_entry_t   prev_out;
    logic        stall_prev;
    logic        out_first;
    int          lasts_in, pkts_begun, acc_count;
    int          errors, sf_errors, words_generated, wd_cycles;
    int          tests_pass, tests_fail, err_mark, acc_base, stall_run;
    int          gen_base;

    tx_buf_top tx_buf_top_i (
        .clk, .reset,
        .in_data, .in_keep, .in_last, .in_valid, .in_ready,
        .out_data, .out_keep, .out_last, .out_valid, .out_ready
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random source and stimulus helpers
    ////////////////////////////////////////////////////////////
    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(inout logic [31:0] state, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);   // one step per bit
            v = {v[62:0], state[0]};
        end
    endtask

    // presents one word, returns at the edge where it was taken
    task automatic send_word(input tx_data_t d, input tx_keep_t k, input logic l, input bit gaps);
        logic [63:0] r;
        logic        ok;
        if (gaps) begin
            draw(in_lfsr, 2, r);
            while (r[1:0] == 2'b00) begin   // idle cycle, one in four
                in_valid <= 1'b0;
                @(posedge clk);
                draw(in_lfsr, 2, r);
            end
        end
        in_valid <= 1'b1;
        in_data  <= d;
        in_keep  <= k;
        in_last  <= l;
        do begin
            @(negedge clk);
            ok = in_ready;              // settled value for the next edge
            @(posedge clk);
        end while (!ok);
    endtask

    task automatic send_packet(input bit gaps);
        logic [63:0] r;
        logic [63:0] d;
        int          len;
        tx_keep_t    k;
        draw(in_lfsr, 5, r);
        len = int'(r[4:0]) + 1;         // 1 .. 32 words
        words_generated += len;
        draw(in_lfsr, 3, r);
        k = tx_keep_t'((9'd1 << (r[2:0] + 4'd1)) - 9'd1);  // contiguous from byte 0
        for (int i = 0; i < len; i++) begin
            draw(in_lfsr, 64, d);
            send_word(d, (i == len - 1) ? k : '1, i == len - 1, gaps);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        assert (!out_valid) else begin
            $display("error %0t: extra output word after the model drained", $time);
            errors++;
        end
    endtask

    task automatic report(input string name, input int errs);
        if (errs == 0) begin
            $display("%s: ok", name);
            tests_pass++;
        end else begin
            $display("%s: FAIL, %0d errors", name, errs);
            tests_fail++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // mac side ready driver
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        case (ready_mode)
            2'd0: out_ready <= 1'b1;
            2'd1: begin
                draw(rdy_lfsr, 2, ready_bits);
                out_ready <= ready_bits[1:0] != 2'b00;
            end
            default: out_ready <= 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // monitor and reference model
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (!reset) begin
            if (stall_prev) begin       // stalled word must hold
                assert (out_valid && {out_data, out_keep, out_last} == prev_out) else begin
                    $display("error %0t: output changed while stalled", $time);
                    errors++;
                end
            end
            if (out_valid && out_first) begin   // no packet before its last input word
                assert (pkts_begun < lasts_in) else begin
                    $display("error %0t: packet %0d started with %0d last words in",
                             $time, pkts_begun, lasts_in);
                    errors++;
                    sf_errors++;
                end
            end
            if (out_valid && out_ready) begin
                got_entry = {out_data, out_keep, out_last};
                assert (exp_q.size() != 0) else begin
                    $display("error %0t: output word %h with no word expected",
                             $time, out_data);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_entry = exp_q.pop_front();
                    assert (got_entry == exp_entry) else begin
                        $display("error %0t: got %h/%h/%b expected %h/%h/%b", $time,
                                 got_entry.data, got_entry.keep, got_entry.last,
                                 exp_entry.data, exp_entry.keep, exp_entry.last);
                        errors++;
                    end
                end
                if (out_first) pkts_begun++;
                out_first = out_last;
            end
            stall_prev = out_valid && !out_ready;
            prev_out   = {out_data, out_keep, out_last};
            if (in_valid && in_ready) begin
                exp_q.push_back({in_data, in_keep, in_last});
                acc_count++;
                if (in_last) lasts_in++;
            end
        end
    end

    // limit grows with the words handed out so far
    initial begin
        wd_cycles = 0;
        while (wd_cycles <= 40 * words_generated + 1000) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("timeout: the buffer stopped moving words after %0d cycles", wd_cycles);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        in_keep = '0;
        in_last = 1'b0;
        out_ready = 1'b1;
        ready_mode = 2'd0;
        in_lfsr = 32'hcd43;
        rdy_lfsr = 32'hcd43;
        stall_prev = 1'b0;
        out_first = 1'b1;
        {lasts_in, pkts_begun, acc_count, errors, sf_errors} = '0;
        {words_generated, tests_pass, tests_fail} = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // 1: idle state after reset
        err_mark = errors;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            $display("error %0t: out_valid %b in_ready %b after reset", $time,
                     out_valid, in_ready);
            errors++;
        end
        @(posedge clk);
        report("reset", errors - err_mark);

        // 2: random gaps on both sides
        err_mark = errors;
        ready_mode <= 2'd1;
        repeat (60) send_packet(1'b1);
        in_valid <= 1'b0;
        wait_drain();
        report("integrity", errors - err_mark);

        // 4: fill the ring with the mac side stalled
        err_mark = errors;
        ready_mode <= 2'd2;
        acc_base = acc_count;
        gen_base = words_generated;
        stall_run = 0;
        fork
            begin
                while (words_generated - gen_base < RING_WORDS + 100) send_packet(1'b0);
                in_valid <= 1'b0;
            end
            begin
                while (stall_run < 16) begin
                    @(negedge clk);
                    stall_run = in_ready ? 0 : stall_run + 1;
                end
                // ring full plus the words parked in the skid fifo
                assert (acc_count - acc_base == RING_WORDS + SKID_WORDS) else begin
                    $display("error %0t: in_ready fell after %0d words, expected %0d",
                             $time, acc_count - acc_base, RING_WORDS + SKID_WORDS);
                    errors++;
                end
                @(posedge clk);
                ready_mode <= 2'd1;
            end
        join
        wait_drain();
        report("back-pressure", errors - err_mark);

        // 5: several laps of the ring
        err_mark = errors;
        gen_base = words_generated;
        while (words_generated - gen_base < 2100) send_packet(1'b1);
        in_valid <= 1'b0;
        wait_drain();
        report("wraparound", errors - err_mark);

        // 3: checked on every output packet above
        report("store-and-forward", sf_errors);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_pass + tests_fail, tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/tx_buf_stream_pkg.sv
design/tx_buf_ctrl_pkg.sv
design/tx_buf_ram.sv
design/tx_buf_writer.sv
design/tx_buf_ctrl.sv
design/tx_buf_reader.sv
design/tx_buf_top.sv
verif/tx_buf_tb.sv
